// ==== chiplet_tx.f ====
+incdir+design
design/chiplet_pkg.sv
design/tx_cache.sv
design/tx_fsm.sv
design/flit_fifo.sv
design/chiplet_tx.sv
test/tx_checker.sv
test/tb_chiplet_tx.sv

// ==== test/tb_chiplet_tx.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tb_chiplet_tx
    import chiplet_pkg::*;
();

    typedef logic [`CHIPLET_ADDR_W-1:0] adr_t;

    localparam adr_t        SEND_ADDR = adr_t'(`CHIPLET_TX_SEND_ADDR);
    localparam logic [39:0] FMTS      = 40'h0112345669; // format sweep from the top nibble down

    logic        clk;
    logic        n_rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    node_id_t    node_id;
    flit_t       flit_out;
    logic        flit_valid;
    logic        flit_ready;
    int          chk_errors;
    int          pending;
    int          flits_exp;
    logic [15:0] lfsr_st [2]; // stimulus, switch ready
    logic [1:0]  ready_mode;  // 0 random, 1 steady, 2 long stalls
    word_t       rdat;
    int          last_waits;
    int          words = 0;
    int          tb_errs = 0;
    int          err_mark = 0;
    int          npass = 0;
    int          nfail = 0;

    chiplet_tx chiplet_tx_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .node_id    (node_id),
        .flit_out   (flit_out),
        .flit_valid (flit_valid),
        .flit_ready (flit_ready)
    );

    tx_checker tx_checker_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .node_id        (node_id),
        .flit_out       (flit_out),
        .flit_valid     (flit_valid),
        .flit_ready     (flit_ready),
        .errors         (chk_errors),
        .pending        (pending),
        .flits_expected (flits_exp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int src, input int n);
        logic [31:0] v;
        logic [15:0] s;
        v = '0;
        s = lfsr_st[src];
        for (int i = 0; i < n; i++) begin
            s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
            v = {v[30:0], s[0]};
        end
        lfsr_st[src] = s;
        return v;
    endfunction

    task automatic wb_access(input logic we, input adr_t adr, input word_t wdat);
        wb_req_t r;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = adr;
        r.dat = wdat;
        words++;
        last_waits = 0;
        wb_req <= r;
        @(posedge clk);
        while (!wb_rsp.ack) begin
            last_waits++;
            @(posedge clk);
        end
        rdat = wb_rsp.dat;
        wb_req <= '0;
        @(posedge clk);
    endtask

    task automatic load_packet(input pkt_id_t slot, input word_t hdr);
        wb_access(1'b1, adr_t'(int'(slot) * `CHIPLET_SLOT_WORDS), hdr);
        for (int i = 1; i < 131; i++) begin // largest packet
            wb_access(1'b1, adr_t'(int'(slot) * `CHIPLET_SLOT_WORDS + i), rand_bits(0, 32));
        end
    endtask

    task automatic drain();
        @(posedge clk);
        while (pending != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (tb_errs + chk_errors == err_mark) begin
            npass++;
            $display("%s: passed", name);
        end else begin
            nfail++;
            $display("%s: failed", name);
        end
        err_mark = tb_errs + chk_errors;
    endtask

    task automatic four_slots(input logic long_only);
        word_t hdr;
        for (int s = 0; s < 4; s++) begin
            hdr = rand_bits(0, 32);
            hdr[31] = 1'b0;
            if (long_only) hdr[31:28] = 4'd1;
            load_packet(pkt_id_t'(s), hdr);
        end
        for (int s = 3; s >= 0; s--) wb_access(1'b1, SEND_ADDR, word_t'(s));
        drain();
    endtask

    initial begin : switch_ready
        int stall_left;
        stall_left = 0;
        lfsr_st[1] = 16'd41;
        flit_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (stall_left > 0) begin
                stall_left--;
                flit_ready <= 1'b0;
            end else if (ready_mode == 2'd1) begin
                flit_ready <= 1'b1;
            end else if (ready_mode == 2'd2 && rand_bits(1, 4) == 0) begin
                stall_left = 10 + int'(rand_bits(1, 4)); // long low stretch
                flit_ready <= 1'b0;
            end else begin
                flit_ready <= rand_bits(1, 2) != 0; // high 3 of 4
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= (words + flits_exp) * 8 + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d expected flits never arrived", cycles, pending);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        word_t hdr;
        word_t vals [16];
        lfsr_st[0] = 16'd41;
        n_rst = 1'b0;
        wb_req = '0;
        ready_mode = 2'd0;
        node_id = node_id_t'(rand_bits(0, 4));
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        @(posedge clk);
        if (wb_rsp.ack !== 1'b0 || flit_valid !== 1'b0) begin
            tb_errs++;
            $display("ack or flit_valid high after reset");
        end

        for (int f = 0; f < 10; f++) begin
            hdr = rand_bits(0, 32);
            hdr[31:28] = FMTS[4*(9-f) +: 4];
            if (f == 2) hdr[6:0] = '0; // 128 data words
            if (f == 8) hdr[3:0] = '0; // 16 data words
            load_packet(pkt_id_t'(f), hdr);
            wb_access(1'b1, SEND_ADDR, word_t'(pkt_id_t'(f)));
            drain();
        end
        end_test("test 1 packet lengths");
        four_slots(1'b0);
        end_test("test 2 flit tags and payloads");
        ready_mode <= 2'd2;
        four_slots(1'b1);
        end_test("test 3 switch back-pressure");

        ready_mode <= 2'd1;
        hdr = rand_bits(0, 32);
        hdr[31:28] = 4'd1;
        hdr[6:0] = 7'd40;
        load_packet(2'd0, hdr);
        load_packet(2'd1, {4'd5, 28'(rand_bits(0, 28))});
        wb_access(1'b1, SEND_ADDR, 32'd0);
        wb_access(1'b1, SEND_ADDR, 32'd1);
        if (last_waits <= `CHIPLET_FIFO_DEPTH) begin
            tb_errs++;
            $display("send to a busy transmitter acked after only %0d cycles", last_waits);
        end
        drain();
        end_test("test 4 send while busy");

        ready_mode <= 2'd0;
        for (int i = 0; i < 16; i++) begin
            vals[i] = rand_bits(0, 32);
            wb_access(1'b1, adr_t'(3 * `CHIPLET_SLOT_WORDS + 160 + i), vals[i]);
        end
        for (int i = 0; i < 16; i++) begin
            wb_access(1'b0, adr_t'(3 * `CHIPLET_SLOT_WORDS + 160 + i), '0);
            if (rdat !== vals[i]) begin
                tb_errs++;
                $display("** Error: wb_rsp.dat expected %h got %h", vals[i], rdat);
            end
        end
        load_packet(2'd0, {4'd1, 21'(rand_bits(0, 21)), 7'd0});
        wb_access(1'b1, SEND_ADDR, 32'd0);
        wb_access(1'b0, SEND_ADDR, '0);
        if (rdat[0] !== 1'b1) begin
            tb_errs++;
            $display("** Error: wb_rsp.dat[0] expected %h got %h", 1'b1, rdat[0]);
        end
        drain();
        wb_access(1'b0, SEND_ADDR, '0);
        if (rdat[0] !== 1'b0) begin
            tb_errs++;
            $display("** Error: wb_rsp.dat[0] expected %h got %h", 1'b0, rdat[0]);
        end
        end_test("test 5 readback and busy status");

        $display("%0d tests passed, %0d tests failed", npass, nfail);
        if (nfail == 0 && tb_errs + chk_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== test/tx_checker.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tx_checker
    import chiplet_pkg::*;
(
    input  logic     clk,
    input  logic     n_rst,
    input  wb_req_t  wb_req,
    input  wb_rsp_t  wb_rsp,
    input  node_id_t node_id,
    input  flit_t    flit_out,
    input  logic     flit_valid,
    input  logic     flit_ready,
    output int       errors,
    output int       pending,
    output int       flits_expected
);

    word_t image [`CHIPLET_MEM_WORDS]; // completed host writes
    flit_t exp_q [$];
    flit_t exp_f;
    flit_t last_flit;
    logic  held = 1'b0;
    int    err_cnt = 0;
    int    exp_cnt = 0;

    function automatic int rule_len(input word_t hdr);
        int dlen;
        int slen;
        int n;
        dlen = (hdr[6:0] == 7'd0) ? 128 : int'(hdr[6:0]);
        slen = (hdr[3:0] == 4'd0) ? 16 : int'(hdr[3:0]);
        case (hdr[31:28])
            4'd0:       n = 3;
            4'd1:       n = 3 + dlen;
            4'd2, 4'd3: n = 2 + dlen;
            4'd4:       n = 1;
            4'd5:       n = 2;
            4'd6:       n = 2 + slen;
            default:    n = 1; // unknown format, header only
        endcase
        return n;
    endfunction

    task automatic queue_packet(input pkt_id_t id);
        int base;
        int n;
        base = int'(id) * `CHIPLET_SLOT_WORDS;
        n = rule_len(image[base]);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back({1'b0, id, node_id, image[base + i]});
        end
        exp_cnt += n;
    endtask

    always @(posedge clk) begin
        if (n_rst) begin
            if (wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
                if (wb_req.adr < `CHIPLET_MEM_WORDS) begin
                    image[wb_req.adr] = wb_req.dat;
                end else if (wb_req.adr == `CHIPLET_TX_SEND_ADDR) begin
                    if (exp_q.size() > `CHIPLET_FIFO_DEPTH) begin // more than the fifo can hold
                        err_cnt++;
                        $display("send acked while %0d flits of the previous packet were unpushed",
                                 exp_q.size());
                    end
                    queue_packet(wb_req.dat[$bits(pkt_id_t)-1:0]);
                end
            end
            if (held && (!flit_valid || flit_out !== last_flit)) begin
                err_cnt++;
                $display("flit_out changed while the switch held ready low");
            end
            held = flit_valid && !flit_ready;
            last_flit = flit_out;
            if (flit_valid && flit_ready) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("extra flit %h arrived with no packet pending", flit_out);
                end else begin
                    exp_f = exp_q.pop_front();
                    if (flit_out !== exp_f) begin
                        err_cnt++;
                        $display("** Error: flit_out expected %h got %h", exp_f, flit_out);
                    end
                end
            end
        end
        errors         <= err_cnt;
        pending        <= exp_q.size();
        flits_expected <= exp_cnt;
    end

endmodule

// ==== design/chiplet_tx.sv ====
`timescale 1ns/1ps

module chiplet_tx
    import chiplet_pkg::*;
(
    input  logic     clk,
    input  logic     n_rst,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    input  node_id_t node_id,
    output flit_t    flit_out,
    output logic     flit_valid,
    input  logic     flit_ready
);

    logic      send_valid;
    pkt_id_t   send_id;
    logic      send_take;
    logic      busy;
    logic      rd_en;
    mem_addr_t rd_addr;
    word_t     rd_data;
    logic      push;
    flit_t     push_flit;
    fifo_cnt_t space;

    tx_cache tx_cache_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .send_valid (send_valid),
        .send_id    (send_id),
        .send_take  (send_take),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .busy       (busy)
    );

    tx_fsm tx_fsm_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .node_id    (node_id),
        .send_valid (send_valid),
        .send_id    (send_id),
        .send_take  (send_take),
        .busy       (busy),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .push       (push),
        .push_flit  (push_flit),
        .space      (space)
    );

    flit_fifo flit_fifo_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .push       (push),
        .push_flit  (push_flit),
        .space      (space),
        .flit_out   (flit_out),
        .flit_valid (flit_valid),
        .flit_ready (flit_ready)
    );

endmodule

// ==== design/flit_fifo.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module flit_fifo
    import chiplet_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  logic      push,
    input  flit_t     push_flit,
    output fifo_cnt_t space,
    output flit_t     flit_out,
    output logic      flit_valid,
    input  logic      flit_ready
);

    localparam int DEPTH = `CHIPLET_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    flit_t ram [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_cnt_t        ram_cnt;
    logic             pop;
    logic             load_out;
    logic             ram_empty;
    logic             to_ram;
    logic             from_ram;

    assign pop       = flit_valid && flit_ready;
    assign load_out  = !flit_valid || pop; // output stage free next cycle
    assign ram_empty = ram_cnt == '0;
    assign from_ram  = load_out && !ram_empty;
    assign to_ram    = push && !(load_out && ram_empty); // else bypass

    // output stage counts as an entry
    assign space = fifo_cnt_t'(DEPTH) - ram_cnt - fifo_cnt_t'(flit_valid);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            ram_cnt    <= '0;
            flit_valid <= 1'b0;
        end else begin
            if (to_ram) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (from_ram) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            ram_cnt <= ram_cnt + fifo_cnt_t'(to_ram) - fifo_cnt_t'(from_ram);
            if (load_out) begin
                flit_valid <= !ram_empty || push;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (to_ram) begin
            ram[wr_ptr] <= push_flit;
        end
        if (load_out) begin
            flit_out <= ram_empty ? push_flit : ram[rd_ptr];
        end
    end

endmodule

// ==== design/tx_fsm.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tx_fsm
    import chiplet_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  node_id_t  node_id,
    input  logic      send_valid,
    input  pkt_id_t   send_id,
    output logic      send_take,
    output logic      busy,
    output logic      rd_en,
    output mem_addr_t rd_addr,
    input  word_t     rd_data,
    output logic      push,
    output flit_t     push_flit,
    input  fifo_cnt_t space
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH_HDR,
        DECODE,
        STREAM
    } state_e;

    state_e    state, next_state;
    pkt_id_t   slot_id;
    word_idx_t pkt_len;
    word_idx_t rd_idx;
    word_idx_t hdr_len;
    logic      inflight;
    pkt_hdr_u  hdr;

    function automatic word_idx_t long_len(input logic [6:0] len);
        return (len == '0) ? word_idx_t'(128) : word_idx_t'(len);
    endfunction

    function automatic word_idx_t short_len(input logic [3:0] len);
        return (len == '0) ? word_idx_t'(16) : word_idx_t'(len);
    endfunction

    assign hdr = pkt_hdr_u'(rd_data);

    always_comb begin
        case (hdr.long_hdr.fmt)
            FMT_LONG_READ:   hdr_len = word_idx_t'(3); // hdr, addr, crc
            FMT_LONG_WRITE:  hdr_len = word_idx_t'(3) + long_len(hdr.long_hdr.length);
            FMT_MEM_RESP:    hdr_len = word_idx_t'(2) + long_len(hdr.resp_hdr.length);
            FMT_MSG:         hdr_len = word_idx_t'(2) + long_len(hdr.msg_hdr.length);
            FMT_SWITCH_CFG:  hdr_len = word_idx_t'(1);
            FMT_SHORT_READ:  hdr_len = word_idx_t'(2);
            FMT_SHORT_WRITE: hdr_len = word_idx_t'(2) + short_len(hdr.short_hdr.length);
            default:         hdr_len = word_idx_t'(1); // unknown, header only
        endcase
    end

    assign send_take = (state == IDLE) && send_valid;
    assign rd_addr   = {slot_id, rd_idx};

    always_comb begin
        rd_en = 1'b0;
        case (state)
            FETCH_HDR: rd_en = space != '0;
            STREAM:    rd_en = (rd_idx < pkt_len) && (space > fifo_cnt_t'(inflight));
            default:   rd_en = 1'b0;
        endcase
    end

    assign push = (state == DECODE) || ((state == STREAM) && inflight);

    always_comb begin
        push_flit.vc      = 1'b0;
        push_flit.id      = slot_id;
        push_flit.req     = node_id;
        push_flit.payload = rd_data;
    end

    // busy until the last flit has left the fifo
    assign busy = (state != IDLE) || (space != fifo_cnt_t'(`CHIPLET_FIFO_DEPTH));

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (send_valid) next_state = FETCH_HDR;
            FETCH_HDR: if (rd_en) next_state = DECODE;
            DECODE:    next_state = (hdr_len == word_idx_t'(1)) ? IDLE : STREAM;
            STREAM:    if (inflight && rd_idx == pkt_len) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            slot_id  <= '0;
            pkt_len  <= '0;
            rd_idx   <= '0;
            inflight <= 1'b0;
        end else begin
            state    <= next_state;
            inflight <= rd_en && (state == STREAM);
            case (state)
                IDLE: begin
                    if (send_take) begin
                        slot_id <= send_id;
                        rd_idx  <= '0;
                    end
                end
                DECODE: begin
                    pkt_len <= hdr_len;
                    rd_idx  <= word_idx_t'(1); // header already pushed
                end
                STREAM: begin
                    if (rd_en) begin
                        rd_idx <= rd_idx + word_idx_t'(1);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== design/tx_cache.sv ====
`timescale 1ns/1ps
`include "chiplet_cfg.svh"

module tx_cache
    import chiplet_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    output logic      send_valid,
    output pkt_id_t   send_id,
    input  logic      send_take,
    input  logic      rd_en,
    input  mem_addr_t rd_addr,
    output word_t     rd_data,
    input  logic      busy
);

    word_t mem [`CHIPLET_MEM_WORDS];

    logic      req;
    logic      is_mem;
    logic      send_hit;
    logic      send_wr;
    logic      ack_q;
    logic      send_pend;
    word_t     rsp_dat;
    mem_addr_t host_idx;
    word_t     reg_dat;

    assign req      = wb_req.cyc && wb_req.stb;
    assign is_mem   = wb_req.adr < `CHIPLET_ADDR_W'(`CHIPLET_MEM_WORDS);
    assign send_hit = wb_req.adr == `CHIPLET_ADDR_W'(`CHIPLET_TX_SEND_ADDR);
    assign send_wr  = req && wb_req.we && send_hit;
    assign host_idx = wb_req.adr[`CHIPLET_MEM_AW-1:0];

    // only the send register is readable in the register page
    assign reg_dat = send_hit ? word_t'(busy) : '0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ack_q     <= 1'b0;
            send_pend <= 1'b0;
            send_id   <= '0;
        end else begin
            ack_q <= req && !send_wr && !ack_q; // one cycle ack, no repeat
            if (send_take) begin
                send_pend <= 1'b0;
            end else if (send_wr && !send_pend) begin
                send_pend <= 1'b1;
                send_id   <= wb_req.dat[$bits(pkt_id_t)-1:0];
            end
        end
    end

    // host port
    always_ff @(posedge clk) begin
        if (req && wb_req.we && is_mem && !ack_q) begin
            mem[host_idx] <= wb_req.dat;
        end
        if (req && !ack_q) begin
            rsp_dat <= is_mem ? mem[host_idx] : reg_dat;
        end
    end

    // fsm port, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    assign send_valid = send_pend;

    // send write acks in the cycle the fsm takes it
    assign wb_rsp.ack = ack_q || send_take;
    assign wb_rsp.dat = rsp_dat;

endmodule

// ==== design/chiplet_pkg.sv ====
`include "chiplet_cfg.svh"

package chiplet_pkg;

    typedef logic [`CHIPLET_DATA_W-1:0] word_t;
    typedef logic [`CHIPLET_MEM_AW-1:0] mem_addr_t;
    typedef logic [`CHIPLET_SLOT_AW-1:0] word_idx_t; // index inside a slot
    typedef logic [`CHIPLET_FIFO_CNT_W-1:0] fifo_cnt_t;

    typedef logic [$clog2(`CHIPLET_PKT_SLOTS)-1:0] pkt_id_t;
    typedef logic [3:0] node_id_t;

    typedef enum logic [3:0] {
        FMT_LONG_READ   = 4'd0,
        FMT_LONG_WRITE  = 4'd1,
        FMT_MEM_RESP    = 4'd2,
        FMT_MSG         = 4'd3,
        FMT_SWITCH_CFG  = 4'd4,
        FMT_SHORT_READ  = 4'd5,
        FMT_SHORT_WRITE = 4'd6
    } pkt_fmt_e;

    // all headers are one 32-bit word, format always in the top nibble
    typedef struct packed {
        pkt_fmt_e   fmt;
        node_id_t   dest;
        logic [7:0] tag;
        logic [8:0] addr_hi;
        logic [6:0] length; // 0 means 128
    } long_hdr_t;

    typedef struct packed {
        pkt_fmt_e    fmt;
        node_id_t    dest;
        logic [7:0]  tag;
        logic [11:0] addr;
        logic [3:0]  length; // 0 means 16
    } short_hdr_t;

    typedef struct packed {
        pkt_fmt_e   fmt;
        node_id_t   dest;
        logic [7:0] msg_code;
        logic [8:0] rsvd;
        logic [6:0] length;
    } msg_hdr_t;

    typedef struct packed {
        pkt_fmt_e   fmt;
        node_id_t   dest;
        logic [7:0] tag;
        logic [8:0] status;
        logic [6:0] length;
    } resp_hdr_t;

    typedef struct packed {
        pkt_fmt_e    fmt;
        node_id_t    dest;
        logic [7:0]  cfg_addr;
        logic [15:0] cfg_data;
    } switch_cfg_hdr_t;

    typedef union packed {
        long_hdr_t       long_hdr;
        short_hdr_t      short_hdr;
        msg_hdr_t        msg_hdr;
        resp_hdr_t       resp_hdr;
        switch_cfg_hdr_t cfg_hdr;
    } pkt_hdr_u;

    typedef struct packed {
        logic     vc;
        pkt_id_t  id;
        node_id_t req;
        word_t    payload;
    } flit_t;

    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`CHIPLET_ADDR_W-1:0] adr;
        word_t                      dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

endpackage

// ==== design/chiplet_cfg.svh ====
`ifndef CHIPLET_CFG_SVH
`define CHIPLET_CFG_SVH

// packet memory layout
`define CHIPLET_PKT_SLOTS 4
`define CHIPLET_SLOT_WORDS 256
`define CHIPLET_MEM_WORDS (`CHIPLET_PKT_SLOTS * `CHIPLET_SLOT_WORDS)
`define CHIPLET_MEM_AW $clog2(`CHIPLET_MEM_WORDS)
`define CHIPLET_SLOT_AW $clog2(`CHIPLET_SLOT_WORDS)

// host bus
`define CHIPLET_ADDR_W 11
`define CHIPLET_DATA_W 32

// register page, word address
`define CHIPLET_TX_SEND_ADDR 1024

// switch side buffering
`define CHIPLET_FIFO_DEPTH 8
`define CHIPLET_FIFO_CNT_W $clog2(`CHIPLET_FIFO_DEPTH + 1)

`endif
